/* hdl/vm_config.svh */
`ifndef VM_CONFIG_SVH
`define VM_CONFIG_SVH

// generic instruction opcodes
`define VM_OP_MOV_CONST 8'h00
`define VM_OP_MOV       8'h01
`define VM_OP_ADD       8'h02
`define VM_OP_ADD_CONST 8'h03
`define VM_OP_CALL      8'h04
`define VM_OP_RET       8'h05
`define VM_OP_JMP       8'h07
`define VM_OP_DJNZ      8'h09
`define VM_OP_COND_JMP  8'h0A
`define VM_OP_SUB       8'h13
`define VM_OP_AND       8'h14
`define VM_OP_OR        8'h15
`define VM_OP_SHL       8'h16
`define VM_OP_SHR       8'h17

// storage sizes and word width
`define VM_VAR_COUNT    256
`define VM_STACK_DEPTH  256
`define VM_WORD_BITS    16

// condJmp subopcode flags, relation sits in bits 2:0
`define VM_COND_VAR_BIT  7
`define VM_COND_WIDE_BIT 6

`endif

/* hdl/vm_pkg.sv */
package vm_pkg;

  // program byte and variable value
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // program address, also what the call stack holds
  typedef logic [15:0] pc_t;

  // variable index and stack pointer
  typedef logic [7:0]  idx_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_shl,
    alu_shr,
    alu_dec,
    alu_pass,
    alu_cmp_eq,
    alu_cmp_ne,
    alu_cmp_gt,
    alu_cmp_ge,
    alu_cmp_lt,
    alu_cmp_le
  } alu_op_t;

  // one step per program byte, then execute
  typedef enum logic [2:0] {
    st_fetch,
    st_operand1,
    st_operand2,
    st_operand3,
    st_operand4,
    st_execute,
    st_halted
  } seq_state_t;

endpackage

/* hdl/vm_store.sv */
`timescale 1ns/10ps

module vm_store #(
  parameter type entry_t = logic [15:0]
) (
  input  logic       clk,
  input  logic       we,
  input  logic [7:0] waddr,
  input  entry_t     wdata,
  input  logic [7:0] raddr_a,
  output entry_t     rdata_a,
  input  logic [7:0] raddr_b,
  output entry_t     rdata_b
);

  entry_t mem [0:255];

  // single write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // two asynchronous read ports
  assign rdata_a = mem[raddr_a];
  assign rdata_b = mem[raddr_b];

endmodule

/* hdl/vm_alu.sv */
`timescale 1ns/10ps

`include "vm_config.svh"

module vm_alu import vm_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    cond
);

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      // whole 16-bit count, anything past the word clears it
      alu_shl: begin
        if (b >= `VM_WORD_BITS) begin
          result = '0;
        end else begin
          result = a << b[3:0];
        end
      end
      alu_shr: begin
        if (b >= `VM_WORD_BITS) begin
          result = '0;
        end else begin
          result = a >> b[3:0];
        end
      end
      alu_dec:  result = a - 16'd1;
      alu_pass: result = b;
      // unsigned relations of a against b
      alu_cmp_eq: cond = (a == b);
      alu_cmp_ne: cond = (a != b);
      alu_cmp_gt: cond = (a > b);
      alu_cmp_ge: cond = (a >= b);
      alu_cmp_lt: cond = (a < b);
      alu_cmp_le: cond = (a <= b);
      default: begin
        result = '0;
        cond   = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/vm_sequencer.sv */
`timescale 1ns/10ps

`include "vm_config.svh"

module vm_sequencer import vm_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  output pc_t     prog_addr,
  input  byte_t   prog_data,
  output alu_op_t alu_op,
  output word_t   alu_a,
  output word_t   alu_b,
  input  word_t   alu_result,
  input  logic    alu_cond,
  output logic    var_we,
  output idx_t    var_addr,
  output word_t   var_wdata,
  output idx_t    var_raddr_a,
  input  word_t   var_rdata_a,
  output idx_t    var_raddr_b,
  input  word_t   var_rdata_b,
  output logic    stack_we,
  output idx_t    stack_addr,
  output pc_t     stack_wdata,
  input  pc_t     stack_rdata,
  output logic    halted
);

  seq_state_t state;
  pc_t        pc;
  idx_t       sp;
  byte_t      opcode;
  byte_t      subopcode;
  idx_t       dst;
  idx_t       src;
  word_t      operand;
  // second byte of a two-byte field in operand3/operand4
  logic       second;
  // condJmp relation result, taken before the target overwrites operand
  logic       cond_hit;
  logic       is_cond;
  logic       writes_var;

  assign is_cond = (opcode == `VM_OP_COND_JMP);

  ////////////////////////////////////////////////////////////////////////////
  // step machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state    <= st_fetch;
      pc       <= '0;
      sp       <= '0;
      second   <= 1'b0;
      cond_hit <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          opcode <= prog_data;
          case (prog_data)
            `VM_OP_RET: begin
              pc    <= pc + 16'd1;
              state <= st_execute;
            end
            `VM_OP_MOV_CONST, `VM_OP_MOV, `VM_OP_ADD, `VM_OP_ADD_CONST, `VM_OP_CALL,
            `VM_OP_JMP, `VM_OP_DJNZ, `VM_OP_COND_JMP, `VM_OP_SUB, `VM_OP_AND,
            `VM_OP_OR, `VM_OP_SHL, `VM_OP_SHR: begin
              pc    <= pc + 16'd1;
              state <= st_operand1;
            end
            // unknown opcode, pc stays on it
            default: state <= st_halted;
          endcase
        end
        st_operand1: begin
          pc    <= pc + 16'd1;
          state <= st_operand2;
          case (opcode)
            `VM_OP_JMP, `VM_OP_CALL: operand[15:8] <= prog_data;
            `VM_OP_COND_JMP:         subopcode <= prog_data;
            default:                 dst <= prog_data;
          endcase
        end
        st_operand2: begin
          pc <= pc + 16'd1;
          case (opcode)
            `VM_OP_JMP, `VM_OP_CALL: begin
              operand[7:0] <= prog_data;
              state        <= st_execute;
            end
            `VM_OP_MOV_CONST, `VM_OP_SHL, `VM_OP_SHR, `VM_OP_DJNZ: begin
              operand[15:8] <= prog_data;
              state         <= st_operand3;
            end
            `VM_OP_ADD_CONST: begin
              operand <= {8'h00, prog_data};
              state   <= st_execute;
            end
            `VM_OP_COND_JMP: begin
              src   <= prog_data;
              state <= st_operand3;
            end
            default: begin
              src   <= prog_data;
              state <= st_execute;
            end
          endcase
        end
        st_operand3: begin
          pc <= pc + 16'd1;
          if (!is_cond) begin
            operand[7:0] <= prog_data;
            state        <= st_execute;
          end else if (second) begin
            operand[7:0] <= prog_data;
            second       <= 1'b0;
            state        <= st_operand4;
          end else if (subopcode[`VM_COND_VAR_BIT]) begin
            // comparand is a variable, the wide flag does not apply
            dst   <= prog_data;
            state <= st_operand4;
          end else if (subopcode[`VM_COND_WIDE_BIT]) begin
            operand[15:8] <= prog_data;
            second        <= 1'b1;
          end else begin
            operand <= {8'h00, prog_data};
            state   <= st_operand4;
          end
        end
        // condJmp target, high byte then low byte
        st_operand4: begin
          pc <= pc + 16'd1;
          if (!second) begin
            cond_hit      <= alu_cond && (subopcode[2:1] != 2'b11);
            operand[15:8] <= prog_data;
            second        <= 1'b1;
          end else begin
            operand[7:0] <= prog_data;
            second       <= 1'b0;
            state        <= st_execute;
          end
        end
        st_execute: begin
          state <= st_fetch;
          case (opcode)
            `VM_OP_JMP: pc <= operand;
            `VM_OP_CALL: begin
              sp <= sp + 8'd1;
              pc <= operand;
            end
            `VM_OP_RET: begin
              sp <= sp - 8'd1;
              pc <= stack_rdata;
            end
            `VM_OP_DJNZ: begin
              if (alu_result != '0) begin
                pc <= operand;
              end
            end
            `VM_OP_COND_JMP: begin
              if (cond_hit) begin
                pc <= operand;
              end
            end
            default: pc <= pc;
          endcase
        end
        default: state <= st_halted;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_a = var_rdata_a;
    alu_b = var_rdata_b;
    case (opcode)
      `VM_OP_MOV_CONST, `VM_OP_ADD_CONST, `VM_OP_SHL, `VM_OP_SHR: alu_b = operand;
      `VM_OP_COND_JMP: begin
        if (!subopcode[`VM_COND_VAR_BIT]) begin
          alu_b = operand;
        end
      end
      default: alu_b = var_rdata_b;
    endcase
  end

  always_comb begin
    case (opcode)
      `VM_OP_ADD, `VM_OP_ADD_CONST: alu_op = alu_add;
      `VM_OP_SUB:  alu_op = alu_sub;
      `VM_OP_AND:  alu_op = alu_and;
      `VM_OP_OR:   alu_op = alu_or;
      `VM_OP_SHL:  alu_op = alu_shl;
      `VM_OP_SHR:  alu_op = alu_shr;
      `VM_OP_DJNZ: alu_op = alu_dec;
      `VM_OP_COND_JMP: begin
        case (subopcode[2:0])
          3'd0:    alu_op = alu_cmp_eq;
          3'd1:    alu_op = alu_cmp_ne;
          3'd2:    alu_op = alu_cmp_gt;
          3'd3:    alu_op = alu_cmp_ge;
          3'd4:    alu_op = alu_cmp_lt;
          default: alu_op = alu_cmp_le;
        endcase
      end
      default: alu_op = alu_pass;
    endcase
  end

  always_comb begin
    case (opcode)
      `VM_OP_MOV_CONST, `VM_OP_MOV, `VM_OP_ADD, `VM_OP_ADD_CONST, `VM_OP_SUB,
      `VM_OP_AND, `VM_OP_OR, `VM_OP_SHL, `VM_OP_SHR, `VM_OP_DJNZ: writes_var = 1'b1;
      default: writes_var = 1'b0;
    endcase
  end

  // condJmp reads its tested variable on a, comparand index on b
  assign var_raddr_a = is_cond ? src : dst;
  assign var_raddr_b = is_cond ? dst : src;

  assign var_we    = (state == st_execute) && writes_var;
  assign var_addr  = dst;
  assign var_wdata = alu_result;

  // push at sp, pop from sp minus 1
  assign stack_we    = (state == st_execute) && (opcode == `VM_OP_CALL);
  assign stack_addr  = (opcode == `VM_OP_RET) ? sp - 8'd1 : sp;
  assign stack_wdata = pc;

  assign prog_addr = pc;
  assign halted    = (state == st_halted);

endmodule

/* hdl/vm_top.sv */
`timescale 1ns/10ps

module vm_top import vm_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  output pc_t   prog_addr,
  input  byte_t prog_data,
  output logic  var_we,
  output idx_t  var_addr,
  output word_t var_data,
  output logic  halted
);

  alu_op_t alu_op;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_result;
  logic    alu_cond;
  idx_t    var_raddr_a;
  idx_t    var_raddr_b;
  word_t   var_rdata_a;
  word_t   var_rdata_b;
  logic    stack_we;
  idx_t    stack_addr;
  pc_t     stack_wdata;
  pc_t     stack_rdata;

  vm_sequencer seq0 (
    .clk         (clk),
    .reset       (reset),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .alu_op      (alu_op),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_result  (alu_result),
    .alu_cond    (alu_cond),
    .var_we      (var_we),
    .var_addr    (var_addr),
    .var_wdata   (var_data),
    .var_raddr_a (var_raddr_a),
    .var_rdata_a (var_rdata_a),
    .var_raddr_b (var_raddr_b),
    .var_rdata_b (var_rdata_b),
    .stack_we    (stack_we),
    .stack_addr  (stack_addr),
    .stack_wdata (stack_wdata),
    .stack_rdata (stack_rdata),
    .halted      (halted)
  );

  vm_alu alu0 (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .cond   (alu_cond)
  );

  // variable file
  vm_store #(.entry_t(word_t)) vars0 (
    .clk     (clk),
    .we      (var_we),
    .waddr   (var_addr),
    .wdata   (var_data),
    .raddr_a (var_raddr_a),
    .rdata_a (var_rdata_a),
    .raddr_b (var_raddr_b),
    .rdata_b (var_rdata_b)
  );

  // call stack, one address for push and pop
  vm_store #(.entry_t(pc_t)) stack0 (
    .clk     (clk),
    .we      (stack_we),
    .waddr   (stack_addr),
    .wdata   (stack_wdata),
    .raddr_a (stack_addr),
    .rdata_a (stack_rdata),
    .raddr_b (stack_addr),
    .rdata_b ()
  );

endmodule

/* bench/vm_top_sva.sv */
`timescale 1ns/10ps

module vm_top_sva import vm_pkg::*; (
  input logic clk,
  input logic reset,
  input logic var_we,
  input logic halted,
  input pc_t  prog_addr
);

  int fail_count = 0;

  // halted is sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (!reset) halted |=> halted)
    else begin
      fail_count++;
      $error("halted fell while reset was high");
    end

  no_write_halted: assert property (@(posedge clk) disable iff (!reset) halted |-> !var_we)
    else begin
      fail_count++;
      $error("var_we high while halted");
    end

  // fetch stops once halted
  addr_frozen: assert property (@(posedge clk) disable iff (!reset)
                                halted |=> $stable(prog_addr))
    else begin
      fail_count++;
      $error("prog_addr moved while halted");
    end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/10ps

`include "vm_config.svh"

module tb_top import vm_pkg::*; ();

  localparam int num_programs    = 40;
  localparam int max_prog_bytes  = 200;
  localparam int clk_period_ns   = 4;
  localparam int watchdog_ns     = num_programs * max_prog_bytes * 8 * clk_period_ns;
  localparam int body_limit      = 150;
  localparam int sub0_addr       = 176;
  localparam int sub1_addr       = 188;
  localparam int max_model_steps = 2000;
  localparam byte_t halt_opcode  = 8'h06;

  localparam byte_t alu_opcodes [0:8] = '{
    `VM_OP_MOV_CONST, `VM_OP_MOV, `VM_OP_ADD, `VM_OP_ADD_CONST, `VM_OP_SUB,
    `VM_OP_AND, `VM_OP_OR, `VM_OP_SHL, `VM_OP_SHR
  };

  logic  clk;
  logic  reset;
  pc_t   prog_addr;
  byte_t prog_data;
  logic  var_we;
  idx_t  var_addr;
  word_t var_data;
  logic  halted;

  byte_t       prog_mem [0:255];
  word_t       model_vars [0:`VM_VAR_COUNT-1];
  idx_t        exp_addr_q [$];
  word_t       exp_data_q [$];
  logic        model_halted;
  logic [31:0] rng_state;
  int          pos;
  idx_t        var_base;
  int          var_count;

  vm_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .var_we    (var_we),
    .var_addr  (var_addr),
    .var_data  (var_data),
    .halted    (halted)
  );

  bind vm_top vm_top_sva sva0 (
    .clk       (clk),
    .reset     (reset),
    .var_we    (var_we),
    .halted    (halted),
    .prog_addr (prog_addr)
  );

  always #2 clk = ~clk;

  // unused bytes decode as unknown opcodes so a stray pc halts
  function automatic byte_t fill_byte(input pc_t a);
    return {1'b1, a[6:0] ^ a[13:7] ^ {5'b00000, a[15:14]}};
  endfunction

  // program memory answers combinationally
  assign prog_data = (prog_addr < 16'd256) ? prog_mem[prog_addr[7:0]] : fill_byte(prog_addr);

  //////////////////////////////////////////////////////////////////////////
  // failure reporting and compares
  //////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_idx(input string name, input idx_t got, input idx_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s is %b, expected %b",
                                  $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // program generator
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_below(input int n);
    return int'(xorshift32() % n);
  endfunction

  // first variable of the set is reserved as loop counter
  function automatic idx_t data_var();
    return idx_t'(int'(var_base) + 1 + rand_below(var_count - 1));
  endfunction

  function automatic idx_t any_var();
    return idx_t'(int'(var_base) + rand_below(var_count));
  endfunction

  // shift counts mostly small and sometimes past the word width
  function automatic word_t shift_count();
    if (rand_below(4) == 0) begin
      return word_t'(xorshift32());
    end else begin
      return word_t'(rand_below(18));
    end
  endfunction

  task automatic emit(input byte_t b);
    prog_mem[pos] = b;
    pos++;
  endtask

  task automatic emit_pc(input pc_t a);
    emit(a[15:8]);
    emit(a[7:0]);
  endtask

  // forward target at the current end of code
  task automatic patch_target(input int at);
    pc_t t;
    t = pc_t'(pos);
    prog_mem[at] = t[15:8];
    prog_mem[at + 1] = t[7:0];
  endtask

  task automatic gen_alu();
    byte_t op;
    op = alu_opcodes[rand_below(9)];
    emit(op);
    emit(data_var());
    case (op)
      `VM_OP_MOV_CONST:       emit_pc(pc_t'(xorshift32()));
      `VM_OP_ADD_CONST:       emit(byte_t'(xorshift32()));
      `VM_OP_SHL, `VM_OP_SHR: emit_pc(shift_count());
      default:                emit(any_var());
    endcase
  endtask

  task automatic gen_block();
    int n;
    int i;
    n = 1 + rand_below(2);
    for (i = 0; i < n; i++) begin
      gen_alu();
    end
  endtask

  // condJmp over a short block in any relation and comparand form
  task automatic gen_cond_skip();
    byte_t sub;
    int    form;
    int    at;
    form = rand_below(3);
    sub = byte_t'(rand_below(6));
    if (form == 1) begin
      sub[`VM_COND_WIDE_BIT] = 1'b1;
    end else if (form == 2) begin
      sub[`VM_COND_VAR_BIT] = 1'b1;
    end
    emit(`VM_OP_COND_JMP);
    emit(sub);
    emit(any_var());
    if (form == 1) begin
      emit_pc(pc_t'(xorshift32()));
    end else if (form == 2) begin
      emit(any_var());
    end else begin
      emit(byte_t'(xorshift32()));
    end
    at = pos;
    emit_pc('0);
    gen_block();
    patch_target(at);
  endtask

  task automatic build_program();
    int i;
    int kind;
    int at;
    int loop_start;
    for (i = 0; i < 256; i++) begin
      prog_mem[i] = fill_byte(pc_t'(i));
    end
    pos = 0;
    var_count = 3 + rand_below(5);
    var_base = idx_t'(rand_below(`VM_VAR_COUNT + 1 - var_count));
    for (i = 0; i < var_count; i++) begin
      emit(`VM_OP_MOV_CONST);
      emit(idx_t'(int'(var_base) + i));
      emit_pc(pc_t'(xorshift32()));
    end
    at = pos;
    // subroutine area where the second one nests a call to the first
    pos = sub0_addr;
    gen_block();
    emit(`VM_OP_RET);
    pos = sub1_addr;
    gen_alu();
    emit(`VM_OP_CALL);
    emit_pc(pc_t'(sub0_addr));
    emit(`VM_OP_RET);
    pos = at;
    while (pos < body_limit) begin
      kind = rand_below(8);
      case (kind)
        4: begin
          emit(`VM_OP_JMP);
          at = pos;
          emit_pc('0);
          gen_block();
          patch_target(at);
        end
        5: gen_cond_skip();
        6: begin
          emit(`VM_OP_MOV_CONST);
          emit(var_base);
          emit_pc(pc_t'(1 + rand_below(4)));
          loop_start = pos;
          gen_block();
          emit(`VM_OP_DJNZ);
          emit(var_base);
          emit_pc(pc_t'(loop_start));
        end
        7: begin
          emit(`VM_OP_CALL);
          emit_pc(pc_t'((rand_below(2) == 0) ? sub0_addr : sub1_addr));
        end
        default: gen_alu();
      endcase
    end
    emit(halt_opcode);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // instruction-level reference model
  //////////////////////////////////////////////////////////////////////////

  function automatic word_t mem_word(input pc_t a);
    return {prog_mem[a], prog_mem[a + 16'd1]};
  endfunction

  function automatic word_t alu_model(input byte_t op, input word_t a, input word_t b);
    case (op)
      `VM_OP_ADD, `VM_OP_ADD_CONST: return a + b;
      `VM_OP_SUB: return a - b;
      `VM_OP_AND: return a & b;
      `VM_OP_OR:  return a | b;
      `VM_OP_SHL: return (b >= 16'd16) ? 16'd0 : word_t'(a << b);
      `VM_OP_SHR: return (b >= 16'd16) ? 16'd0 : word_t'(a >> b);
      default:    return b;
    endcase
  endfunction

  // unsigned relation of the tested variable against the comparand
  function automatic logic relation_holds(input logic [2:0] rel, input word_t a,
                                          input word_t b);
    case (rel)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd2:    return a > b;
      3'd3:    return a >= b;
      3'd4:    return a < b;
      3'd5:    return a <= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic model_write(input idx_t d, input word_t w);
    exp_addr_q.push_back(d);
    exp_data_q.push_back(w);
    model_vars[d] = w;
  endtask

  task automatic run_model();
    pc_t   pc;
    pc_t   p;
    pc_t   stack_q [$];
    byte_t op;
    byte_t sub;
    idx_t  d;
    idx_t  s;
    word_t cmp;
    word_t w;
    int    steps;
    int    i;
    for (i = 0; i < `VM_VAR_COUNT; i++) begin
      model_vars[i] = '0;
    end
    exp_addr_q.delete();
    exp_data_q.delete();
    pc = '0;
    steps = 0;
    model_halted = 1'b0;
    while (!model_halted) begin
      steps++;
      if (steps > max_model_steps) begin
        stop_with_failure("reference model never reached the halt opcode");
      end
      op = prog_mem[pc];
      d = prog_mem[pc + 16'd1];
      s = prog_mem[pc + 16'd2];
      case (op)
        `VM_OP_MOV_CONST, `VM_OP_SHL, `VM_OP_SHR: begin
          model_write(d, alu_model(op, model_vars[d], mem_word(pc + 16'd2)));
          pc = pc + 16'd4;
        end
        `VM_OP_MOV, `VM_OP_ADD, `VM_OP_SUB, `VM_OP_AND, `VM_OP_OR: begin
          model_write(d, alu_model(op, model_vars[d], model_vars[s]));
          pc = pc + 16'd3;
        end
        `VM_OP_ADD_CONST: begin
          model_write(d, alu_model(op, model_vars[d], {8'h00, s}));
          pc = pc + 16'd3;
        end
        `VM_OP_JMP: pc = mem_word(pc + 16'd1);
        `VM_OP_CALL: begin
          if (stack_q.size() >= `VM_STACK_DEPTH) begin
            stop_with_failure("reference model overflowed the call stack");
          end
          stack_q.push_back(pc + 16'd3);
          pc = mem_word(pc + 16'd1);
        end
        `VM_OP_RET: begin
          if (stack_q.size() == 0) begin
            stop_with_failure("reference model hit ret with an empty call stack");
          end
          pc = stack_q.pop_back();
        end
        `VM_OP_DJNZ: begin
          w = model_vars[d] - 16'd1;
          model_write(d, w);
          pc = (w != 16'd0) ? mem_word(pc + 16'd2) : pc + 16'd4;
        end
        `VM_OP_COND_JMP: begin
          sub = d;
          p = pc + 16'd3;
          if (sub[`VM_COND_VAR_BIT]) begin
            cmp = model_vars[prog_mem[p]];
            p = p + 16'd1;
          end else if (sub[`VM_COND_WIDE_BIT]) begin
            cmp = mem_word(p);
            p = p + 16'd2;
          end else begin
            cmp = {8'h00, prog_mem[p]};
            p = p + 16'd1;
          end
          if (relation_holds(sub[2:0], model_vars[s], cmp)) begin
            pc = mem_word(p);
          end else begin
            pc = p + 16'd2;
          end
        end
        default: model_halted = 1'b1;
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // per-program run and checks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_write();
    idx_t  e_addr;
    word_t e_data;
    if (exp_addr_q.size() == 0) begin
      stop_with_failure("the DUT wrote a variable after all expected writes were seen");
    end
    e_addr = exp_addr_q.pop_front();
    e_data = exp_data_q.pop_front();
    compare_idx("var_addr", var_addr, e_addr);
    compare_word("var_data", var_data, e_data);
  endtask

  task automatic run_program();
    logic seen_halt;
    int   i;
    @(posedge clk);
    #1;
    reset = 1'b0;
    build_program();
    run_model();
    // reset stays low over two rising edges
    @(posedge clk);
    @(negedge clk);
    compare_bit("var_we", var_we, 1'b0);
    compare_bit("halted", halted, 1'b0);
    compare_pc("prog_addr", prog_addr, '0);
    @(posedge clk);
    #1;
    reset = 1'b1;
    seen_halt = 1'b0;
    // outputs sampled at the falling edge
    while (!seen_halt) begin
      @(negedge clk);
      if (var_we) begin
        check_write();
      end
      seen_halt = halted;
    end
    if (exp_addr_q.size() != 0) begin
      stop_with_failure($sformatf("the DUT halted with %0d expected variable writes missing",
                                  exp_addr_q.size()));
    end
    for (i = 0; i < 3; i++) begin
      @(negedge clk);
      compare_bit("var_we", var_we, 1'b0);
      compare_bit("halted", halted, model_halted);
    end
  endtask

  always @(negedge clk) begin
    if (dut0.sva0.fail_count != 0) begin
      stop_with_failure("an assertion on the DUT outputs failed");
    end
  end

  initial begin
    #(watchdog_ns);
    stop_with_failure("watchdog expired before all programs finished");
  end

  initial begin
    int prog_num;
    int i;
    clk = 1'b0;
    reset = 1'b0;
    rng_state = 32'd48664;
    for (i = 0; i < 256; i++) begin
      prog_mem[i] = fill_byte(pc_t'(i));
    end
    for (prog_num = 0; prog_num < num_programs; prog_num++) begin
      run_program();
    end
    @(negedge clk);
    if (dut0.sva0.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_failure("an assertion on the DUT outputs failed");
    end
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/vm_pkg.sv
hdl/vm_store.sv
hdl/vm_alu.sv
hdl/vm_sequencer.sv
hdl/vm_top.sv
bench/vm_top_sva.sv
bench/tb_top.sv

/* Makefile */
SOURCES := tb.f $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

all: run

obj_dir/Vtb_top: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top

run: obj_dir/Vtb_top
	obj_dir/Vtb_top +verilator+error+limit+100

clean:
	rm -rf obj_dir

.PHONY: all run clean
